// File: Makefile
# Verilator build and run for the KMAC key-prefix stage
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= kmac_core_tb
FILELIST  ?= kmac_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Verdict comes from the log, not from the simulator exit code
run: compile
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Result: PASS"; \
	else \
	  echo "Result: FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: kmac_core.f
source/kmac_pkg.sv
source/kmac_key_encoder.sv
source/kmac_key_feeder.sv
source/kmac_ctrl_fsm.sv
source/kmac_core.sv
tb/kmac_core_assert.sv
tb/kmac_core_tb.sv

// File: source/kmac_core.sv
// KMAC key-prefix stage between the message FIFO and the SHA3 engine
// Prepends bytepad(encode_string(K), rate) when KMAC is enabled
// Configuration inputs must stay stable from start until done

`timescale 1ns/10ps

module kmac_core
  import kmac_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Message FIFO side
  input  logic                 fifo_valid_i,
  input  msg_beat_t            fifo_beat_i,
  output logic                 fifo_ready_o,

  // SHA3 engine side
  output logic                 msg_valid_o,
  output msg_beat_t            msg_beat_o,
  input  logic                 msg_ready_i,

  // Configuration
  input  logic                 kmac_en_i,
  input  strength_e            strength_i,
  input  key_len_e             key_len_i,
  input  logic [MaxKeyLen-1:0] key_data_i,

  // Commands
  input  logic                 start_i,
  input  logic                 process_i,
  input  logic                 done_i,
  output logic                 process_o,

  // Escalation
  input  logic                 escalate_i,
  output logic                 fsm_error_o
);

  logic       key_phase;
  logic       clr_idx;
  logic       block_sent;
  logic       key_valid;
  msg_beat_t  key_beat;
  key_block_u key_block;

  //////////////////////////////////////////////////////////////////////
  // Key path
  //////////////////////////////////////////////////////////////////////

  kmac_key_encoder u_encoder (
    .key_data_i  (key_data_i),
    .key_len_i   (key_len_i),
    .strength_i  (strength_i),
    .key_block_o (key_block)
  );

  kmac_key_feeder u_feeder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .key_phase_i  (key_phase),
    .clr_idx_i    (clr_idx),
    .strength_i   (strength_i),
    .key_block_i  (key_block),
    .msg_ready_i  (msg_ready_i),
    .key_valid_o  (key_valid),
    .key_beat_o   (key_beat),
    .block_sent_o (block_sent)
  );

  kmac_ctrl_fsm u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .kmac_en_i    (kmac_en_i),
    .start_i      (start_i),
    .process_i    (process_i),
    .done_i       (done_i),
    .escalate_i   (escalate_i),
    .block_sent_i (block_sent),
    .key_phase_o  (key_phase),
    .clr_idx_o    (clr_idx),
    .process_o    (process_o),
    .fsm_error_o  (fsm_error_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Message mux
  //////////////////////////////////////////////////////////////////////

  // FIFO is held off while the key block owns the engine
  assign msg_valid_o  = key_phase ? key_valid : fifo_valid_i;
  assign msg_beat_o   = key_phase ? key_beat  : fifo_beat_i;
  assign fifo_ready_o = key_phase ? 1'b0      : msg_ready_i;

endmodule

// File: source/kmac_ctrl_fsm.sv
// Control FSM for the key-prefix stage
// Sparse state codes; any illegal code or escalation ends in TerminalError
// TerminalError is left only through reset

`timescale 1ns/10ps

module kmac_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic kmac_en_i,
  input  logic start_i,
  input  logic process_i,
  input  logic done_i,
  input  logic escalate_i,

  // From key feeder
  input  logic block_sent_i,

  output logic key_phase_o,
  output logic clr_idx_o,
  output logic process_o,
  output logic fsm_error_o
);

  //////////////////////////////////////////////////////////////////////
  // State encoding
  //////////////////////////////////////////////////////////////////////

  // 6-bit codes, minimum Hamming distance 3
  typedef enum logic [5:0] {
    StIdle          = 6'b011000,
    StKey           = 6'b010111,
    StMsg           = 6'b001110,
    StFlush         = 6'b101011,
    StTerminalError = 6'b100000
  } ctrl_st_e;

  ctrl_st_e state_q, state_d;

  // Request toward the engine, only issued once the key block is out
  logic kmac_process;
  logic process_latched;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    key_phase_o  = 1'b0;
    clr_idx_o    = 1'b0;
    kmac_process = 1'b0;
    fsm_error_o  = 1'b0;

    case (state_q)
      StIdle: begin
        if (kmac_en_i && start_i) begin
          state_d = StKey;
        end
      end

      // Full rate block of key goes out regardless of process
      StKey: begin
        key_phase_o = 1'b1;
        if (block_sent_i) begin
          clr_idx_o = 1'b1;
          state_d   = StMsg;
        end
      end

      // FIFO message passes through, wait for a process request
      StMsg: begin
        if (process_i || process_latched) begin
          kmac_process = 1'b1;
          state_d      = StFlush;
        end
      end

      StFlush: begin
        if (done_i) begin
          state_d = StIdle;
        end
      end

      StTerminalError: begin
        fsm_error_o = 1'b1;
      end

      default: begin
        fsm_error_o = 1'b1;
        state_d     = StTerminalError;
      end
    endcase

    // Escalation overrides everything
    if (escalate_i) begin
      state_d = StTerminalError;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Process latch
  //////////////////////////////////////////////////////////////////////

  // Catches a process that arrives before the key block is finished
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_latched <= 1'b0;
    end else if (process_i && !process_o) begin
      process_latched <= 1'b1;
    end else if (process_o || done_i) begin
      process_latched <= 1'b0;
    end
  end

  // Plain SHA3 use forwards process untouched
  assign process_o = kmac_en_i ? kmac_process : process_i;

endmodule

// File: source/kmac_key_encoder.sv
// Builds bytepad(encode_string(K), rate) as one flat rate-sized block
// Purely combinational; key and configuration must be stable while in use
// Bits above the encoded key are zero, so any rate can read the same block

`timescale 1ns/10ps

module kmac_key_encoder
  import kmac_pkg::*;
(
  input  logic [MaxKeyLen-1:0] key_data_i,
  input  key_len_e             key_len_i,
  input  strength_e            strength_i,
  output key_block_u           key_block_o
);

  //////////////////////////////////////////////////////////////////////
  // Prefix fields
  //////////////////////////////////////////////////////////////////////

  // left_encode(rate) is always two bytes, 01 then the rate in bytes
  logic [15:0] rate_enc;

  // left_encode(len(K)) in byte stream order, byte 0 in the low bits
  // Two-byte lengths leave the top byte unused
  logic [23:0] len_enc;

  // Bytes taken by left_encode(len(K)), either 2 or 3
  logic        len_is_3b;

  assign rate_enc = {rate_bytes(strength_i), 8'h01};

  always_comb begin
    len_enc   = '0;
    len_is_3b = 1'b0;
    case (key_len_i)
      // 128 -> 01 80
      Key128: len_enc = 24'h00_8001;
      // 192 -> 01 C0
      Key192: len_enc = 24'h00_C001;
      // 256 -> 02 01 00
      Key256: begin
        len_enc   = 24'h00_0102;
        len_is_3b = 1'b1;
      end
      // 384 -> 02 01 80
      Key384: begin
        len_enc   = 24'h80_0102;
        len_is_3b = 1'b1;
      end
      // 512 -> 02 02 00
      Key512: begin
        len_enc   = 24'h00_0202;
        len_is_3b = 1'b1;
      end
      default: len_enc = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Block assembly
  //////////////////////////////////////////////////////////////////////

  // Layout from bit 0 upward: rate_enc, len_enc, key, zero fill
  always_comb begin
    key_block_o.flat        = '0;
    key_block_o.flat[15:0]  = rate_enc;

    if (len_is_3b) begin
      key_block_o.flat[39:16] = len_enc;
    end else begin
      key_block_o.flat[31:16] = len_enc[15:0];
    end

    // Key starts right after the length field
    case (key_len_i)
      Key128:  key_block_o.flat[32 +: 128] = key_data_i[127:0];
      Key192:  key_block_o.flat[32 +: 192] = key_data_i[191:0];
      Key256:  key_block_o.flat[40 +: 256] = key_data_i[255:0];
      Key384:  key_block_o.flat[40 +: 384] = key_data_i[383:0];
      Key512:  key_block_o.flat[40 +: 512] = key_data_i[511:0];
      default: key_block_o.flat[MaxKeyLen+39:16] = '0;
    endcase
  end

endmodule

// File: source/kmac_key_feeder.sv
// Streams the padded key block to the engine one 64-bit word at a time
// Stops after rate_words(strength) accepted beats
// Strength must not change during the key phase

`timescale 1ns/10ps

module kmac_key_feeder
  import kmac_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // From control FSM
  input  logic       key_phase_i,
  input  logic       clr_idx_i,
  input  strength_e  strength_i,

  // Encoded key block
  input  key_block_u key_block_i,

  // Engine side
  input  logic       msg_ready_i,
  output logic       key_valid_o,
  output msg_beat_t  key_beat_o,

  // Whole rate block accepted
  output logic       block_sent_o
);

  logic [KeyIdxW-1:0]  key_idx;
  logic [KeyIdxW-1:0]  idx_limit;
  logic [MsgWidth-1:0] key_word;

  //////////////////////////////////////////////////////////////////////
  // Word index
  //////////////////////////////////////////////////////////////////////

  // Advances only on a real transfer so back-pressure holds the word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_idx <= '0;
    end else if (clr_idx_i) begin
      key_idx <= '0;
    end else if (key_valid_o && msg_ready_i) begin
      key_idx <= key_idx + KeyIdxW'(1);
    end
  end

  assign idx_limit    = rate_words(strength_i);
  assign block_sent_o = (key_idx == idx_limit);

  //////////////////////////////////////////////////////////////////////
  // Word select
  //////////////////////////////////////////////////////////////////////

  // Index can sit one past the last word at the end of an L128 block
  assign key_word = (key_idx < KeyIdxW'(KeyBlockWords)) ?
                    key_block_i.words[key_idx] : '0;

  assign key_valid_o = key_phase_i && !block_sent_o;

  // Key words are always full width
  assign key_beat_o.data = key_valid_o ? key_word : '0;
  assign key_beat_o.strb = key_valid_o ? '1 : '0;

endmodule

// File: source/kmac_pkg.sv
// Shared widths, types and rate tables for the KMAC key-prefix stage
// Single share only; the key block is sized for the largest rate (L128)
// Key lengths above MaxKeyLen are not supported

package kmac_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // One message word toward the engine
  parameter int MsgWidth = 64;
  parameter int MsgStrbW = MsgWidth / 8;

  // Longest secret key in bits
  parameter int MaxKeyLen = 512;

  // Words in the largest rate block (1344 bits for L128)
  parameter int KeyBlockWords = 21;

  // Index must reach KeyBlockWords itself to flag the end of a block
  parameter int KeyIdxW = 5;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    Key128 = 3'd0,
    Key192 = 3'd1,
    Key256 = 3'd2,
    Key384 = 3'd3,
    Key512 = 3'd4
  } key_len_e;

  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } strength_e;

  // One beat on the message interface
  typedef struct packed {
    logic [MsgWidth-1:0] data;
    logic [MsgStrbW-1:0] strb;
  } msg_beat_t;

  // Padded key block, built as a flat vector and read out word by word
  typedef union packed {
    logic [KeyBlockWords*MsgWidth-1:0]      flat;
    logic [KeyBlockWords-1:0][MsgWidth-1:0] words;
  } key_block_u;

  //////////////////////////////////////////////////////////////////////
  // Rate tables
  //////////////////////////////////////////////////////////////////////

  // Rate in 64-bit words
  function automatic logic [KeyIdxW-1:0] rate_words(strength_e s);
    case (s)
      L128:    return KeyIdxW'(21);
      L224:    return KeyIdxW'(18);
      L256:    return KeyIdxW'(17);
      L384:    return KeyIdxW'(13);
      L512:    return KeyIdxW'(9);
      default: return '0;
    endcase
  endfunction

  // Rate in bytes, used as the bytepad width
  function automatic logic [7:0] rate_bytes(strength_e s);
    case (s)
      L128:    return 8'd168;
      L224:    return 8'd144;
      L256:    return 8'd136;
      L384:    return 8'd104;
      L512:    return 8'd72;
      default: return 8'd0;
    endcase
  endfunction

endpackage

// File: tb/kmac_core_assert.sv
// Protocol checks for the KMAC key-prefix stage, bound into kmac_core
// Assumes kmac_en_i is not dropped in the middle of a key phase

`timescale 1ns/10ps

module kmac_core_assert
  import kmac_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      kmac_en_i,
  input logic      fifo_valid_i,
  input msg_beat_t fifo_beat_i,
  input logic      fifo_ready_i,
  input logic      msg_valid_i,
  input msg_beat_t msg_beat_i,
  input logic      msg_ready_i,
  input logic      process_i,
  input logic      proc_out_i,
  input logic      escalate_i,
  input logic      fsm_error_i,
  input logic      key_phase_i,
  input logic      clr_idx_i
);

  // Failed checks so far, polled by the testbench
  int unsigned fail_cnt = 0;

  // Process request seen while the key block was still going out
  logic proc_pend;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      proc_pend <= 1'b0;
    end else if (proc_out_i) begin
      proc_pend <= 1'b0;
    end else if (key_phase_i && process_i) begin
      proc_pend <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Message path
  //////////////////////////////////////////////////////////////////////

  // Plain SHA3 use is a straight wire
  a_pass_through: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !kmac_en_i && !key_phase_i |-> msg_valid_i == fifo_valid_i &&
      msg_beat_i == fifo_beat_i && fifo_ready_i == msg_ready_i && proc_out_i == process_i)
    else begin
      $error("Pass-through path differs from FIFO inputs");
      fail_cnt++;
    end

  // FIFO held off while key words go out
  a_fifo_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    key_phase_i |-> !fifo_ready_i)
    else begin
      $error("fifo_ready_o high during key phase");
      fail_cnt++;
    end

  // Stalled key beat stays put
  a_key_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    key_phase_i && msg_valid_i && !msg_ready_i && !escalate_i
      |=> msg_valid_i && $stable(msg_beat_i))
    else begin
      $error("Key beat changed under back-pressure");
      fail_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // Process and escalation
  //////////////////////////////////////////////////////////////////////

  a_no_proc_in_key: assert property (@(posedge clk_i) disable iff (!rst_ni)
    key_phase_i |-> !proc_out_i)
    else begin
      $error("process_o during key phase");
      fail_cnt++;
    end

  // Early request comes out right after the last key beat
  a_proc_after_key: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_idx_i && (proc_pend || process_i) |=> proc_out_i)
    else begin
      $error("Latched process not issued after key block");
      fail_cnt++;
    end

  a_proc_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    proc_out_i && kmac_en_i |=> !proc_out_i)
    else begin
      $error("process_o high for two cycles");
      fail_cnt++;
    end

  a_escalate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalate_i |=> fsm_error_i)
    else begin
      $error("fsm_error_o not raised after escalation");
      fail_cnt++;
    end

  // Only reset leaves the terminal state
  a_error_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_error_i |=> fsm_error_i && !key_phase_i)
    else begin
      $error("Terminal error state left without reset");
      fail_cnt++;
    end

endmodule

bind kmac_core kmac_core_assert u_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .kmac_en_i    (kmac_en_i),
  .fifo_valid_i (fifo_valid_i),
  .fifo_beat_i  (fifo_beat_i),
  .fifo_ready_i (fifo_ready_o),
  .msg_valid_i  (msg_valid_o),
  .msg_beat_i   (msg_beat_o),
  .msg_ready_i  (msg_ready_i),
  .process_i    (process_i),
  .proc_out_i   (process_o),
  .escalate_i   (escalate_i),
  .fsm_error_i  (fsm_error_o),
  .key_phase_i  (key_phase),
  .clr_idx_i    (clr_idx)
);

// File: tb/kmac_core_tb.sv
// Testbench for the KMAC key-prefix stage
// Key words are compared with a local bytepad model built from left_encode rules
// Engine back-pressure is random from a fixed seed; protocol rules sit in kmac_core_assert

`timescale 1ns/10ps

module kmac_core_tb
  import kmac_pkg::*;
();

  // 5 key runs of up to 21 words at about 4 cycles each, plus messages and margin
  localparam int MaxCycles   = 4000;
  localparam int ResetCycles = 16;

  // Security level and key size per enum position
  localparam int SecBits [5] = '{128, 224, 256, 384, 512};
  localparam int KeyBits [5] = '{128, 192, 256, 384, 512};

  logic                 clk_i;
  logic                 rst_ni;
  logic                 fifo_valid_i;
  msg_beat_t            fifo_beat_i;
  logic                 fifo_ready_o;
  logic                 msg_valid_o;
  msg_beat_t            msg_beat_o;
  logic                 msg_ready_i;
  logic                 kmac_en_i;
  strength_e            strength_i;
  key_len_e             key_len_i;
  logic [MaxKeyLen-1:0] key_data_i;
  logic                 start_i;
  logic                 process_i;
  logic                 done_i;
  logic                 process_o;
  logic                 escalate_i;
  logic                 fsm_error_o;

  integer seed;
  int     cycle_cnt   = 0;
  int     proc_pulses = 0;
  int     run;

  kmac_core uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "Stopped at cycle %0d", cycle_cnt);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog and monitors
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      stop_fail($sformatf("Timeout: run did not finish in %0d cycles", MaxCycles));
    end
  end

  // Assertion failures and process_o pulses seen mid-cycle
  always @(negedge clk_i) begin
    if (uut.u_assert.fail_cnt != 0) begin
      stop_fail("A protocol assertion failed");
    end
    if (process_o) begin
      proc_pulses = proc_pulses + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Key block model
  //////////////////////////////////////////////////////////////////////

  // bytepad(left_encode(rate) || left_encode(len) || K) with byte 0 at bit 0
  function automatic logic [KeyBlockWords*MsgWidth-1:0] expected_block(
    input logic [MaxKeyLen-1:0] key, input int key_bits, input int sec_bits);
    logic [KeyBlockWords*MsgWidth-1:0] blk;
    int pos;
    int i;
    blk = '0;
    blk[7:0]  = 8'h01;
    // Rate in bytes is 200 minus twice the capacity share
    blk[15:8] = 8'(200 - sec_bits / 4);
    if (key_bits > 255) begin
      blk[23:16] = 8'h02;
      blk[31:24] = 8'(key_bits >> 8);
      blk[39:32] = 8'(key_bits);
      pos = 5;
    end else begin
      blk[23:16] = 8'h01;
      blk[31:24] = 8'(key_bits);
      pos = 4;
    end
    for (i = 0; i < key_bits / 8; i++) begin
      blk[8*(pos+i) +: 8] = key[8*i +: 8];
    end
    return blk;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks start and end 10 ns after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic pass_through_run();
    int i;
    kmac_en_i = 1'b0;
    for (i = 0; i < 24; i++) begin
      fifo_valid_i     = 1'($random(seed));
      fifo_beat_i.data = {$random(seed), $random(seed)};
      fifo_beat_i.strb = MsgStrbW'($random(seed));
      msg_ready_i      = 1'($random(seed));
      process_i        = (($random(seed) & 7) == 0);
      start_i          = (($random(seed) & 7) == 0);
      @(posedge clk_i);
      #10;
    end
    fifo_valid_i = 1'b0;
    process_i    = 1'b0;
    start_i      = 1'b0;
  endtask

  task automatic key_run(input int r);
    logic [KeyBlockWords*MsgWidth-1:0] exp_blk;
    logic [MsgWidth-1:0]               exp_word;
    int words;
    int beats;
    int p0;
    int i;
    bit key_done;
    bit proc_hit;
    words = (200 - SecBits[r] / 4) / 8;
    for (i = 0; i < MaxKeyLen / 32; i++) begin
      key_data_i[32*i +: 32] = $random(seed);
    end
    kmac_en_i  = 1'b1;
    key_len_i  = key_len_e'(3'(r));
    strength_i = strength_e'(3'(r));
    exp_blk    = expected_block(key_data_i, KeyBits[r], SecBits[r]);
    p0         = proc_pulses;
    start_i    = 1'b1;
    @(posedge clk_i);
    #10;
    start_i  = 1'b0;
    beats    = 0;
    key_done = 1'b0;
    proc_hit = 1'b0;
    // FIFO ready shows up again only once the key phase is over
    while (!key_done) begin
      msg_ready_i = (($random(seed) & 3) != 0);
      process_i   = (r % 2 == 0) && (beats == 2) && !proc_hit;
      if (process_i) begin
        proc_hit = 1'b1;
      end
      @(negedge clk_i);
      if (fifo_ready_o) begin
        key_done = 1'b1;
      end else if (msg_valid_o && msg_ready_i) begin
        exp_word = exp_blk[MsgWidth*beats +: MsgWidth];
        if (beats >= words) begin
          stop_fail($sformatf("Key beat %0d sent past the end of the rate block", beats));
        end else if (msg_beat_o.data !== exp_word) begin
          stop_fail($sformatf("Mismatch msg_beat_o.data word %0d: got %h expected %h",
                              beats, msg_beat_o.data, exp_word));
        end else if (msg_beat_o.strb !== '1) begin
          stop_fail($sformatf("Mismatch msg_beat_o.strb: got %h expected %h",
                              msg_beat_o.strb, 8'hff));
        end
        beats++;
      end
      @(posedge clk_i);
      #10;
    end
    if (beats != words) begin
      stop_fail($sformatf("Mismatch key beat count: got %h expected %h", beats, words));
    end
    process_i   = 1'b0;
    msg_ready_i = 1'b1;
    // Message words follow the key unchanged
    for (i = 0; i < 3; i++) begin
      fifo_valid_i     = 1'b1;
      fifo_beat_i.data = {$random(seed), $random(seed)};
      fifo_beat_i.strb = '1;
      @(negedge clk_i);
      if (!msg_valid_o || msg_beat_o !== fifo_beat_i) begin
        stop_fail($sformatf("Mismatch msg_beat_o: got %h expected %h",
                            msg_beat_o, fifo_beat_i));
      end
      @(posedge clk_i);
      #10;
    end
    fifo_valid_i = 1'b0;
    if (r % 2 == 1) begin
      process_i = 1'b1;
      @(posedge clk_i);
      #10;
      process_i = 1'b0;
    end
    @(negedge clk_i);
    if (proc_pulses - p0 != 1) begin
      stop_fail($sformatf("Expected one process_o pulse, saw %0d", proc_pulses - p0));
    end
    @(posedge clk_i);
    #10;
    done_i = 1'b1;
    @(posedge clk_i);
    #10;
    done_i = 1'b0;
  endtask

  task automatic escalation_run();
    kmac_en_i   = 1'b1;
    key_len_i   = Key256;
    strength_i  = L256;
    msg_ready_i = 1'b0;
    start_i     = 1'b1;
    @(posedge clk_i);
    #10;
    start_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #10;
    escalate_i = 1'b1;
    @(posedge clk_i);
    #10;
    escalate_i = 1'b0;
    @(negedge clk_i);
    if (!fsm_error_o) begin
      stop_fail("fsm_error_o did not rise after escalation");
    end
    @(posedge clk_i);
    #10;
    // Commands must not move the FSM out of the error state
    start_i   = 1'b1;
    done_i    = 1'b1;
    process_i = 1'b1;
    @(posedge clk_i);
    #10;
    start_i   = 1'b0;
    done_i    = 1'b0;
    process_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    if (!fsm_error_o || msg_valid_o) begin
      stop_fail("Terminal error state was left without a reset");
    end
    @(posedge clk_i);
    #10;
    rst_ni = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (fsm_error_o) begin
      stop_fail("fsm_error_o still high after reset");
    end
    @(posedge clk_i);
    #10;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'h0460066d;
    rst_ni       = 1'b0;
    fifo_valid_i = 1'b0;
    fifo_beat_i  = '0;
    msg_ready_i  = 1'b0;
    kmac_en_i    = 1'b0;
    strength_i   = L128;
    key_len_i    = Key128;
    key_data_i   = '0;
    start_i      = 1'b0;
    process_i    = 1'b0;
    done_i       = 1'b0;
    escalate_i   = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #10;
    pass_through_run();
    for (run = 0; run < 5; run++) begin
      key_run(run);
    end
    escalation_run();
    @(negedge clk_i);
    if (uut.u_assert.fail_cnt == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      stop_fail("A protocol assertion failed");
    end
  end

endmodule
